/* Bender.yml */
package:
  name: mem_shell

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_shell_pkg.sv
      - hw/voxel_debug_port.sv
      - hw/sdram_stub.sv
      - hw/mem_port_router.sv
      - hw/mem_shell_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/tb_mem_shell.sv

/* hw/mem_port_router.sv */
// Single-beat memory port router
// Decodes each request once, steers it to the voxel port or the SDRAM stub
// and merges the two response streams back onto one port

`default_nettype none

`include "mem_shell_consts.svh"

module mem_port_router (
    input  logic                     clk,
    input  logic                     rst_n,
    // External port
    input  mem_shell_pkg::mem_addr_u awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`MEM_DATA_W-1:0]   wdata,
    input  logic [`MEM_STRB_W-1:0]   wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  mem_shell_pkg::mem_addr_u araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`MEM_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // Request strobes to the targets
    output logic                     voxel_wr,
    output logic                     voxel_rd,
    output logic                     sdram_wr,
    output logic                     sdram_rd,
    output mem_shell_pkg::mem_addr_u tgt_addr_wr,
    output mem_shell_pkg::mem_addr_u tgt_addr_rd,
    output logic [`MEM_DATA_W-1:0]   tgt_wdata,
    output logic [`MEM_STRB_W-1:0]   tgt_wstrb,
    // Target responses
    input  logic                     voxel_bvalid,
    input  logic                     voxel_rvalid,
    input  logic                     sdram_bvalid,
    input  logic                     sdram_rvalid,
    input  logic [`MEM_DATA_W-1:0]   sdram_rdata,
    input  logic [1:0]               sdram_bresp,
    input  logic [1:0]               sdram_rresp,
    output logic                     voxel_bready,
    output logic                     voxel_rready,
    output logic                     sdram_bready,
    output logic                     sdram_rready
);
    import mem_shell_pkg::*;

    logic wr_accept;
    logic rd_accept;
    logic aw_is_voxel;
    logic ar_is_voxel;
    logic wr_owner_sdram;
    logic rd_owner_sdram;

    // BAR1 aliases fold back onto the bottom of SDRAM
    function automatic mem_addr_u rebase(input mem_addr_u a);
        logic [`MEM_ADDR_W-1:0] raw;
        raw = a;
        if (raw >= `BAR1_BASE)
            return raw - `BAR1_BASE;
        return raw;
    endfunction

    // ------------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------------
    assign aw_is_voxel = (awaddr.win_view.win_sel == '0);
    assign ar_is_voxel = (araddr.win_view.win_sel == '0);

    // Address and data phases are taken together, one response in flight
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;

    assign voxel_wr    = wr_accept && aw_is_voxel;
    assign sdram_wr    = wr_accept && !aw_is_voxel;
    assign voxel_rd    = rd_accept && ar_is_voxel;
    assign sdram_rd    = rd_accept && !ar_is_voxel;
    assign tgt_addr_wr = rebase(awaddr);
    assign tgt_addr_rd = rebase(araddr);
    assign tgt_wdata   = wdata;
    assign tgt_wstrb   = wstrb;

    // Owner of each outstanding response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_owner_sdram <= 1'b0;
            rd_owner_sdram <= 1'b0;
        end else begin
            if (wr_accept)
                wr_owner_sdram <= !aw_is_voxel;
            if (rd_accept)
                rd_owner_sdram <= !ar_is_voxel;
        end
    end

    // ------------------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------------------
    assign bvalid = wr_owner_sdram ? sdram_bvalid : voxel_bvalid;
    assign bresp  = wr_owner_sdram ? sdram_bresp : `RESP_OKAY;
    assign rvalid = rd_owner_sdram ? sdram_rvalid : voxel_rvalid;
    assign rresp  = rd_owner_sdram ? sdram_rresp : `RESP_OKAY;
    // Voxel window reads as zero
    assign rdata  = rd_owner_sdram ? sdram_rdata : '0;

    assign voxel_bready = bready && !wr_owner_sdram;
    assign sdram_bready = bready && wr_owner_sdram;
    assign voxel_rready = rready && !rd_owner_sdram;
    assign sdram_rready = rready && rd_owner_sdram;

    // No target is strobed while either target still holds a response
    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        !((voxel_wr || sdram_wr) && (voxel_bvalid || sdram_bvalid)) &&
        !((voxel_rd || sdram_rd) && (voxel_rvalid || sdram_rvalid)));

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

/* hw/mem_shell_consts.svh */
// Shared widths and address map constants for the memory shell
// Window limit, BAR1 rebase point and SDRAM stand-in depth

`ifndef MEM_SHELL_CONSTS_SVH
`define MEM_SHELL_CONSTS_SVH

// Bus widths
`define MEM_ADDR_W      28
`define MEM_DATA_W      64
`define MEM_STRB_W      8
`define VOXEL_ADDR_W    18

// Address map
`define VOXEL_WIN_LIMIT 28'h004_0000
`define BAR1_BASE       28'h100_0000

// SDRAM stand-in depth in 64-bit words
`define SDRAM_WORDS     4096

// Response codes
`define RESP_OKAY       2'b00

`endif

/* hw/mem_shell_pkg.sv */
// Address type shared by the router and both memory targets
// One byte address decoded as a window select or as a word index

`default_nettype none

`include "mem_shell_consts.svh"

package mem_shell_pkg;

    // Window decode view, win_sel of zero means voxel window
    typedef struct packed {
        logic [`MEM_ADDR_W-`VOXEL_ADDR_W-1:0] win_sel;
        logic [`VOXEL_ADDR_W-1:0]             win_offset;
    } mem_win_view_t;

    // 64-bit word view, byte lane dropped for row indexing
    typedef struct packed {
        logic [`MEM_ADDR_W-4:0] word_index;
        logic [2:0]             byte_lane;
    } mem_word_view_t;

    typedef union packed {
        mem_win_view_t  win_view;
        mem_word_view_t word_view;
    } mem_addr_u;

endpackage

`default_nettype wire

/* hw/mem_shell_top.sv */
// Memory shell top level
// Router in front of the voxel debug port and the SDRAM stand-in

`default_nettype none

`include "mem_shell_consts.svh"

module mem_shell_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // External single-beat port
    input  logic [`MEM_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`MEM_DATA_W-1:0]   wdata,
    input  logic [`MEM_STRB_W-1:0]   wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`MEM_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`MEM_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // Voxel debug write
    output logic                     dbg_write_en,
    output logic [`VOXEL_ADDR_W-1:0] dbg_write_addr,
    output logic [`MEM_DATA_W-1:0]   dbg_write_data
);
    import mem_shell_pkg::*;

    logic                   voxel_wr;
    logic                   voxel_rd;
    logic                   sdram_wr;
    logic                   sdram_rd;
    mem_addr_u              tgt_addr_wr;
    mem_addr_u              tgt_addr_rd;
    logic [`MEM_DATA_W-1:0] tgt_wdata;
    logic [`MEM_STRB_W-1:0] tgt_wstrb;
    logic                   voxel_bvalid;
    logic                   voxel_rvalid;
    logic                   voxel_bready;
    logic                   voxel_rready;
    logic                   sdram_bvalid;
    logic                   sdram_rvalid;
    logic                   sdram_bready;
    logic                   sdram_rready;
    logic [`MEM_DATA_W-1:0] sdram_rdata;
    logic [1:0]             sdram_bresp;
    logic [1:0]             sdram_rresp;

    mem_port_router u_router (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .voxel_wr(voxel_wr), .voxel_rd(voxel_rd),
        .sdram_wr(sdram_wr), .sdram_rd(sdram_rd),
        .tgt_addr_wr(tgt_addr_wr), .tgt_addr_rd(tgt_addr_rd),
        .tgt_wdata(tgt_wdata), .tgt_wstrb(tgt_wstrb),
        .voxel_bvalid(voxel_bvalid), .voxel_rvalid(voxel_rvalid),
        .sdram_bvalid(sdram_bvalid), .sdram_rvalid(sdram_rvalid),
        .sdram_rdata(sdram_rdata), .sdram_bresp(sdram_bresp), .sdram_rresp(sdram_rresp),
        .voxel_bready(voxel_bready), .voxel_rready(voxel_rready),
        .sdram_bready(sdram_bready), .sdram_rready(sdram_rready)
    );

    voxel_debug_port u_voxel (
        .clk(clk), .rst_n(rst_n),
        .wr(voxel_wr), .rd(voxel_rd),
        .bready(voxel_bready), .rready(voxel_rready),
        .addr(tgt_addr_wr), .wdata(tgt_wdata),
        .bvalid(voxel_bvalid), .rvalid(voxel_rvalid),
        .dbg_write_en(dbg_write_en),
        .dbg_write_addr(dbg_write_addr),
        .dbg_write_data(dbg_write_data)
    );

    sdram_stub #(
        .mem_words(`SDRAM_WORDS)
    ) u_sdram (
        .clk(clk), .rst_n(rst_n),
        .wr(sdram_wr), .rd(sdram_rd),
        .bready(sdram_bready), .rready(sdram_rready),
        .wr_addr(tgt_addr_wr), .rd_addr(tgt_addr_rd),
        .wdata(tgt_wdata), .wstrb(tgt_wstrb),
        .bvalid(sdram_bvalid), .rvalid(sdram_rvalid),
        .rdata(sdram_rdata), .bresp(sdram_bresp), .rresp(sdram_rresp)
    );

endmodule

`default_nettype wire

/* hw/sdram_stub.sv */
// Block-RAM stand-in for the SDRAM target
// Byte-strobed writes, registered reads, response flags held until ready

`default_nettype none

`include "mem_shell_consts.svh"

module sdram_stub #(
    parameter int mem_words = `SDRAM_WORDS
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr,
    input  logic                     rd,
    input  logic                     bready,
    input  logic                     rready,
    input  mem_shell_pkg::mem_addr_u wr_addr,
    input  mem_shell_pkg::mem_addr_u rd_addr,
    input  logic [`MEM_DATA_W-1:0]   wdata,
    input  logic [`MEM_STRB_W-1:0]   wstrb,
    output logic                     bvalid,
    output logic                     rvalid,
    output logic [`MEM_DATA_W-1:0]   rdata,
    output logic [1:0]               bresp,
    output logic [1:0]               rresp
);
    import mem_shell_pkg::*;

    localparam int row_w = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [`MEM_DATA_W-1:0] mem [mem_words];
    logic [row_w-1:0]       wr_row;
    logic [row_w-1:0]       rd_row;

    // Row wraps modulo the memory depth
    function automatic logic [row_w-1:0] row_of(input mem_addr_u a);
        return row_w'(a.word_view.word_index % mem_words);
    endfunction

    assign wr_row = row_of(wr_addr);
    assign rd_row = row_of(rd_addr);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (wstrb[b])
                    mem[wr_row][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
        // Same-edge read of a written row sees the old word
        if (rd)
            rdata <= mem[rd_row];
    end

    // ------------------------------------------------------------------------
    // Response flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // No error cases in the stand-in
    assign bresp = `RESP_OKAY;
    assign rresp = `RESP_OKAY;

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

/* hw/voxel_debug_port.sv */
// Voxel window target
// Turns each write into a one-cycle debug write and answers reads at once

`default_nettype none

`include "mem_shell_consts.svh"

module voxel_debug_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,
    input  logic                      rd,
    input  logic                      bready,
    input  logic                      rready,
    input  mem_shell_pkg::mem_addr_u  addr,
    input  logic [`MEM_DATA_W-1:0]    wdata,
    output logic                      bvalid,
    output logic                      rvalid,
    output logic                      dbg_write_en,
    output logic [`VOXEL_ADDR_W-1:0]  dbg_write_addr,
    output logic [`MEM_DATA_W-1:0]    dbg_write_data
);
    import mem_shell_pkg::*;

    // Strobe and response flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbg_write_en <= 1'b0;
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
        end else begin
            dbg_write_en <= wr;
            if (wr)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Voxel word address is byte address bits 20..3
    always_ff @(posedge clk) begin
        if (wr) begin
            dbg_write_addr <= addr.word_view.word_index[`VOXEL_ADDR_W-1:0];
            dbg_write_data <= wdata;
        end
    end

    a_no_wr_pending: assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> !bvalid);

    a_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> (addr < `VOXEL_WIN_LIMIT));

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/mem_shell_pkg.sv
hw/voxel_debug_port.sv
hw/sdram_stub.sv
hw/mem_port_router.sv
hw/mem_shell_top.sv
tb/tb_mem_shell.sv

/* tb/tb_mem_shell.sv */
// Testbench for the memory shell top level
// Random SDRAM, voxel window, back-pressure and same-edge traffic
// checked against a word model of the SDRAM stand-in

`default_nettype none

`include "mem_shell_consts.svh"

module tb_mem_shell;

    logic                     clk;
    logic                     rst_n;
    logic [`MEM_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`MEM_DATA_W-1:0]   wdata;
    logic [`MEM_STRB_W-1:0]   wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [`MEM_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`MEM_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;
    logic                     dbg_write_en;
    logic [`VOXEL_ADDR_W-1:0] dbg_write_addr;
    logic [`MEM_DATA_W-1:0]   dbg_write_data;

    // Reference model of the SDRAM stand-in
    logic [`MEM_DATA_W-1:0]   model_mem [`SDRAM_WORDS];
    int                       rows [12];
    integer                   seed;
    int                       errors = 0;
    int                       tests_passed = 0;
    int                       tests_failed = 0;
    int                       dbg_count = 0;
    logic [`VOXEL_ADDR_W-1:0] dbg_addr_seen;
    logic [`MEM_DATA_W-1:0]   dbg_data_seen;

    mem_shell_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .dbg_write_en(dbg_write_en),
        .dbg_write_addr(dbg_write_addr),
        .dbg_write_data(dbg_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Debug strobe monitor, one count per cycle the strobe is high
    always @(negedge clk) begin
        if (dbg_write_en === 1'b1) begin
            dbg_count = dbg_count + 1;
            dbg_addr_seen = dbg_write_addr;
            dbg_data_seen = dbg_write_data;
        end
    end

    // ------------------------------------------------------------------------
    // Random numbers and address map
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic logic [63:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // Direct SDRAM or BAR1 address that lands on the given row
    function automatic logic [27:0] sdram_alias(input int row);
        logic [27:0] a;
        if (rand_below(2) == 0)
            a = `VOXEL_WIN_LIMIT + rand_below(504) * 28'h8000;
        else
            a = `BAR1_BASE + rand_below(7680) * 28'h8000;
        return a + row * 8 + rand_below(8);
    endfunction

    function automatic logic [27:0] voxel_addr(input int row);
        return rand_below(8) * 28'h8000 + row * 8 + rand_below(8);
    endfunction

    function automatic int model_row(input logic [27:0] a);
        logic [27:0] r;
        r = (a >= `BAR1_BASE) ? a - `BAR1_BASE : a;
        return int'((r >> 3) % `SDRAM_WORDS);
    endfunction

    function automatic void model_write(input logic [27:0] a, input logic [63:0] d,
                                        input logic [7:0] s);
        int row;
        row = model_row(a);
        // The voxel window never reaches SDRAM
        if (a >= `VOXEL_WIN_LIMIT) begin
            for (int b = 0; b < 8; b++) begin
                if (s[b])
                    model_mem[row][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endfunction

    // ------------------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------------------
    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at time %0t: %s within 50 cycles", $time, what);
        $display("Something failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, errors - errors_before);
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus tasks, all called on a falling edge
    // ------------------------------------------------------------------------
    task automatic drive_write(input logic [27:0] a, input logic [63:0] d,
                               input logic [7:0] s);
        awaddr  = a;
        wdata   = d;
        wstrb   = s;
        awvalid = 1'b1;
        wvalid  = 1'b1;
    endtask

    task automatic drive_read(input logic [27:0] a);
        araddr  = a;
        arvalid = 1'b1;
    endtask

    task automatic wait_write_accept;
        int cycles;
        cycles = 0;
        #10;
        while (awready !== 1'b1 || wready !== 1'b1) begin
            if (cycles >= 50)
                abort_run("write request was not accepted");
            @(negedge clk);
            #10;
            cycles++;
        end
        @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic wait_read_accept;
        int cycles;
        cycles = 0;
        #10;
        while (arready !== 1'b1) begin
            if (cycles >= 50)
                abort_run("read request was not accepted");
            @(negedge clk);
            #10;
            cycles++;
        end
        @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic write_req(input logic [27:0] a, input logic [63:0] d,
                             input logic [7:0] s);
        @(negedge clk);
        drive_write(a, d, s);
        wait_write_accept();
        model_write(a, d, s);
    endtask

    task automatic read_req(input logic [27:0] a);
        @(negedge clk);
        drive_read(a);
        wait_read_accept();
    endtask

    // Hold bready low for a while, the response and the back-pressure must stay
    task automatic write_resp(input int hold);
        int cycles;
        cycles = 0;
        while (bvalid !== 1'b1) begin
            if (cycles >= 50)
                abort_run("write response did not arrive");
            @(negedge clk);
            cycles++;
        end
        compare_value("bresp", bresp, `RESP_OKAY);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            compare_value("bvalid", bvalid, 1'b1);
            compare_value("awready", awready, 1'b0);
            compare_value("wready", wready, 1'b0);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_resp(input int hold, output logic [63:0] d);
        int cycles;
        cycles = 0;
        while (rvalid !== 1'b1) begin
            if (cycles >= 50)
                abort_run("read response did not arrive");
            @(negedge clk);
            cycles++;
        end
        d = rdata;
        compare_value("rresp", rresp, `RESP_OKAY);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            compare_value("rvalid", rvalid, 1'b1);
            compare_value("arready", arready, 1'b0);
            compare_value("rdata", rdata, d);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_both_accept;
        int cycles;
        cycles = 0;
        #10;
        while (awready !== 1'b1 || arready !== 1'b1) begin
            if (cycles >= 50)
                abort_run("simultaneous read and write were not accepted");
            @(negedge clk);
            #10;
            cycles++;
        end
        @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [27:0] a;
        logic [27:0] b;
        logic [63:0] d;
        logic [63:0] db;
        logic [63:0] got;
        logic [63:0] old_word;
        logic [7:0]  s;
        logic [7:0]  sb;
        int          row;
        int          c0;
        int          e0;

        seed    = 32'hd16c_f6cd;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // 1. Reset state
        e0 = errors;
        compare_value("bvalid", bvalid, 1'b0);
        compare_value("rvalid", rvalid, 1'b0);
        compare_value("dbg_write_en", dbg_write_en, 1'b0);
        end_test("reset", e0);

        // 2. Strobed SDRAM writes through direct and BAR1 aliases
        e0 = errors;
        for (int i = 0; i < 12; i++) begin
            rows[i] = rand_below(`SDRAM_WORDS);
            write_req(sdram_alias(rows[i]), rand_word(), 8'hff);
            write_resp(0);
        end
        for (int i = 0; i < 24; i++) begin
            row = rows[rand_below(12)];
            s = rand_below(256);
            write_req(sdram_alias(row), rand_word(), s);
            write_resp(rand_below(3));
        end
        for (int i = 0; i < 12; i++) begin
            a = sdram_alias(rows[i]);
            read_req(a);
            read_resp(rand_below(3), got);
            compare_value("rdata", got, model_mem[model_row(a)]);
        end
        end_test("sdram", e0);

        // 3. Voxel window write and read
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            row = rows[rand_below(12)];
            a = voxel_addr(row);
            d = rand_word();
            c0 = dbg_count;
            write_req(a, d, rand_below(256));
            write_resp(0);
            repeat (2) @(negedge clk);
            #10;
            compare_value("dbg_write_en pulses", dbg_count - c0, 1);
            compare_value("dbg_write_addr", dbg_addr_seen, a[20:3]);
            compare_value("dbg_write_data", dbg_data_seen, d);
            b = sdram_alias(row);
            read_req(b);
            read_resp(0, got);
            compare_value("rdata", got, model_mem[model_row(b)]);
            read_req(voxel_addr(row));
            read_resp(0, got);
            compare_value("rdata", got, 64'h0);
        end
        end_test("voxel", e0);

        // 4. Back-pressure on both response channels
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = sdram_alias(rows[rand_below(12)]);
            b = sdram_alias(rows[rand_below(12)]);
            d = rand_word();
            db = rand_word();
            s = rand_below(256);
            sb = rand_below(256);
            write_req(a, d, s);
            drive_write(b, db, sb);
            write_resp(1 + rand_below(6));
            wait_write_accept();
            model_write(b, db, sb);
            write_resp(0);

            read_req(a);
            drive_read(b);
            read_resp(1 + rand_below(6), got);
            compare_value("rdata", got, model_mem[model_row(a)]);
            wait_read_accept();
            read_resp(0, got);
            compare_value("rdata", got, model_mem[model_row(b)]);
        end
        end_test("backpressure", e0);

        // 5. Read and write of one row on the same edge
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            row = rows[rand_below(12)];
            a = sdram_alias(row);
            b = sdram_alias(row);
            d = rand_word();
            s = rand_below(256) | 8'h01;
            old_word = model_mem[row];
            @(negedge clk);
            drive_write(a, d, s);
            drive_read(b);
            wait_both_accept();
            model_write(a, d, s);
            write_resp(0);
            read_resp(0, got);
            compare_value("rdata", got, old_word);
            read_req(b);
            read_resp(0, got);
            compare_value("rdata", got, model_mem[row]);
        end
        end_test("same_edge", e0);

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
